// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = pipe_ctrl_tb
FILELIST = pipe_ctrl.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

sim: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

// File: pipe_ctrl.f
rtl/pipe_ctrl_pkg.sv
rtl/alu_ctrl_dec.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/wb_stage.sv
rtl/pipe_ctrl.sv
verif/pipe_ctrl_chk.sv
verif/pipe_ctrl_tb.sv

// File: rtl/alu_ctrl_dec.sv
/* ALU operation and operand select decode for the instruction in X.
   Purely combinational, instantiated by the execute stage */
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl_dec (
  input  wire logic [pipe_ctrl_pkg::INST_W-1:0] x_inst,
  output logic      [3:0]                      alu_sel,
  output logic                                 a_sel,
  output logic                                 b_sel,
  output logic                                 br_un
);

  logic [pipe_ctrl_pkg::OPC_W-1:0] opc;
  logic [2:0]                      f3;
  logic                            f7;
  logic                            is_rtype;
  logic                            is_itype;

  assign opc      = x_inst[pipe_ctrl_pkg::OPC_LSB +: pipe_ctrl_pkg::OPC_W];
  assign f3       = x_inst[pipe_ctrl_pkg::F3_LSB +: 3];
  assign f7       = x_inst[pipe_ctrl_pkg::F7_BIT];
  assign is_rtype = (opc == pipe_ctrl_pkg::OPC_RTYPE);
  assign is_itype = (opc == pipe_ctrl_pkg::OPC_ITYPE);

  always_comb begin
    alu_sel = pipe_ctrl_pkg::ALU_ADD; // Address and PC arithmetic
    if (is_rtype || is_itype) begin
      case (f3)
        pipe_ctrl_pkg::F3_ADD: begin
          // Bit 30 in an I type is immediate, so only R type can subtract
          alu_sel = (is_rtype && f7) ? pipe_ctrl_pkg::ALU_SUB : pipe_ctrl_pkg::ALU_ADD;
        end
        pipe_ctrl_pkg::F3_SLL:  alu_sel = pipe_ctrl_pkg::ALU_SLL;
        pipe_ctrl_pkg::F3_SLT:  alu_sel = pipe_ctrl_pkg::ALU_SLT;
        pipe_ctrl_pkg::F3_SLTU: alu_sel = pipe_ctrl_pkg::ALU_SLTU;
        pipe_ctrl_pkg::F3_XOR:  alu_sel = pipe_ctrl_pkg::ALU_XOR;
        pipe_ctrl_pkg::F3_SR: begin
          alu_sel = f7 ? pipe_ctrl_pkg::ALU_SRA : pipe_ctrl_pkg::ALU_SRL; // srai too
        end
        pipe_ctrl_pkg::F3_OR:   alu_sel = pipe_ctrl_pkg::ALU_OR;
        pipe_ctrl_pkg::F3_AND:  alu_sel = pipe_ctrl_pkg::ALU_AND;
        default:                alu_sel = pipe_ctrl_pkg::ALU_ADD;
      endcase
    end else if (opc == pipe_ctrl_pkg::OPC_LUI) begin
      alu_sel = pipe_ctrl_pkg::ALU_LUI;
    end
  end

  always_comb begin
    case (opc)
      pipe_ctrl_pkg::OPC_BRANCH,
      pipe_ctrl_pkg::OPC_JAL,
      pipe_ctrl_pkg::OPC_AUIPC: a_sel = pipe_ctrl_pkg::A_PC; // Target is PC relative
      default:                  a_sel = pipe_ctrl_pkg::A_RS1;
    endcase
  end

  assign b_sel = !is_rtype; // High selects the immediate

  // Unsigned compare for bltu and bgeu
  assign br_un = (opc == pipe_ctrl_pkg::OPC_BRANCH) &&
                 ((f3 == pipe_ctrl_pkg::F3_BLTU) || (f3 == pipe_ctrl_pkg::F3_BGEU));

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
/* Decode stage control. Steers the PC, flags the kill of the D instruction
   and bypasses a register file write that lands in the same cycle as the read */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                            rst,
  input  wire logic [pipe_ctrl_pkg::INST_W-1:0] inst,
  input  wire logic                            redirect,
  input  wire logic [pipe_ctrl_pkg::REG_W-1:0]  wf_rd,
  input  wire logic                            wf_we,
  output logic      [pipe_ctrl_pkg::INST_W-1:0] d_inst,
  output logic      [1:0]                      pc_sel,
  output logic                                 nop_sel,
  output logic                                 d_fwd_a,
  output logic                                 d_fwd_b
);

  logic [pipe_ctrl_pkg::OPC_W-1:0] opc;
  logic [pipe_ctrl_pkg::REG_W-1:0] rs1;
  logic [pipe_ctrl_pkg::REG_W-1:0] rs2;
  logic                            is_jal;

  assign opc    = inst[pipe_ctrl_pkg::OPC_LSB +: pipe_ctrl_pkg::OPC_W];
  assign rs1    = inst[pipe_ctrl_pkg::RS1_LSB +: pipe_ctrl_pkg::REG_W];
  assign rs2    = inst[pipe_ctrl_pkg::RS2_LSB +: pipe_ctrl_pkg::REG_W];
  assign is_jal = (opc == pipe_ctrl_pkg::OPC_JAL);

  assign d_inst = inst; // Feeds the X register

  // WF writes the register file while D reads it, so the read sees the old value
  assign d_fwd_a = wf_we && (wf_rd == rs1);
  assign d_fwd_b = wf_we && (wf_rd == rs2);

  assign nop_sel = redirect; // Replace D instruction with a NOP

  always_comb begin
    if (rst) begin
      pc_sel = pipe_ctrl_pkg::PC_RESET;
    end else if (redirect) begin
      pc_sel = pipe_ctrl_pkg::PC_REDIRECT; // Beats jal because the jal is being killed
    end else if (is_jal) begin
      pc_sel = pipe_ctrl_pkg::PC_JAL;
    end else begin
      pc_sel = pipe_ctrl_pkg::PC_NEXT;
    end
  end

endmodule

`default_nettype wire

// File: rtl/exec_stage.sv
/* Execute stage control. Holds the X instruction, resolves branches into a
   redirect and picks the forwarding sources for the ALU operands and store data */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [pipe_ctrl_pkg::INST_W-1:0] d_inst,
  input  wire logic                            br_eq,
  input  wire logic                            br_lt,
  input  wire logic [pipe_ctrl_pkg::REG_W-1:0]  wf_rd,
  input  wire logic                            wf_we,
  input  wire logic                            wf_load,
  output logic      [pipe_ctrl_pkg::INST_W-1:0] x_inst,
  output logic                                 redirect,
  output logic                                 br_taken,
  output logic      [3:0]                      alu_sel,
  output logic                                 a_sel,
  output logic                                 b_sel,
  output logic                                 br_un,
  output logic      [1:0]                      x_fwd_a,
  output logic      [1:0]                      x_fwd_b,
  output logic      [1:0]                      rs2_sel
);

  logic [pipe_ctrl_pkg::OPC_W-1:0] opc;
  logic [2:0]                      f3;
  logic [pipe_ctrl_pkg::REG_W-1:0] rs1;
  logic [pipe_ctrl_pkg::REG_W-1:0] rs2;
  logic                            is_branch;
  logic                            is_jalr;
  logic                            reads_rs1;
  logic                            reads_rs2;
  logic                            hit_a;
  logic                            hit_b;
  logic [1:0]                      fwd_src;

  // A redirect kills the instruction now in D
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      x_inst <= pipe_ctrl_pkg::NOP_INST;
    end else begin
      x_inst <= d_inst;
    end
  end

  assign opc       = x_inst[pipe_ctrl_pkg::OPC_LSB +: pipe_ctrl_pkg::OPC_W];
  assign f3        = x_inst[pipe_ctrl_pkg::F3_LSB +: 3];
  assign rs1       = x_inst[pipe_ctrl_pkg::RS1_LSB +: pipe_ctrl_pkg::REG_W];
  assign rs2       = x_inst[pipe_ctrl_pkg::RS2_LSB +: pipe_ctrl_pkg::REG_W];
  assign is_branch = (opc == pipe_ctrl_pkg::OPC_BRANCH);
  assign is_jalr   = (opc == pipe_ctrl_pkg::OPC_JALR);

  alu_ctrl_dec u_alu_ctrl_dec (
    .x_inst  (x_inst),
    .alu_sel (alu_sel),
    .a_sel   (a_sel),
    .b_sel   (b_sel),
    .br_un   (br_un)
  );

  always_comb begin
    br_taken = 1'b0;
    if (is_branch) begin
      case (f3)
        pipe_ctrl_pkg::F3_BEQ:  br_taken = br_eq;
        pipe_ctrl_pkg::F3_BNE:  br_taken = !br_eq;
        pipe_ctrl_pkg::F3_BLT,
        pipe_ctrl_pkg::F3_BLTU: br_taken = br_lt;  // Signedness set by br_un
        pipe_ctrl_pkg::F3_BGE,
        pipe_ctrl_pkg::F3_BGEU: br_taken = !br_lt;
        default:                br_taken = 1'b0;
      endcase
    end
  end

  assign redirect = br_taken || is_jalr;

  // Operand usage by the X instruction
  assign reads_rs1 = (opc != pipe_ctrl_pkg::OPC_LUI) && (opc != pipe_ctrl_pkg::OPC_AUIPC) &&
                     (opc != pipe_ctrl_pkg::OPC_JAL);
  assign reads_rs2 = (opc == pipe_ctrl_pkg::OPC_RTYPE) || is_branch;

  // wf_we is already low for x0
  assign hit_a   = wf_we && (wf_rd == rs1);
  assign hit_b   = wf_we && (wf_rd == rs2);
  assign fwd_src = wf_load ? pipe_ctrl_pkg::FWD_MEM : pipe_ctrl_pkg::FWD_ALU;

  assign x_fwd_a = (reads_rs1 && hit_a) ? fwd_src : pipe_ctrl_pkg::FWD_REG;
  assign x_fwd_b = (reads_rs2 && hit_b) ? fwd_src : pipe_ctrl_pkg::FWD_REG;
  assign rs2_sel = ((opc == pipe_ctrl_pkg::OPC_STORE) && hit_b) ? fwd_src
                                                                : pipe_ctrl_pkg::FWD_REG;

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl.sv
/* Top of the three-stage RV32I control path. Takes the D instruction and the
   branch compare results and drives the select lines of an external datapath */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [pipe_ctrl_pkg::INST_W-1:0] inst,
  input  wire logic                            br_eq,
  input  wire logic                            br_lt,
  output logic      [1:0]                      pc_sel,
  output logic                                 nop_sel,
  output logic                                 d_fwd_a,
  output logic                                 d_fwd_b,
  output logic                                 a_sel,
  output logic                                 b_sel,
  output logic      [3:0]                      alu_sel,
  output logic                                 br_un,
  output logic                                 br_taken,
  output logic      [1:0]                      x_fwd_a,
  output logic      [1:0]                      x_fwd_b,
  output logic      [1:0]                      rs2_sel,
  output logic                                 rf_we,
  output logic      [1:0]                      wb_sel,
  output logic      [2:0]                      ldx_sel
);

  logic [pipe_ctrl_pkg::INST_W-1:0] d_inst;
  logic [pipe_ctrl_pkg::INST_W-1:0] x_inst;
  logic                             redirect;  // Taken branch or jalr in X
  logic [pipe_ctrl_pkg::REG_W-1:0]  wf_rd;
  logic                             wf_we;
  logic                             wf_load;

  decode_stage u_decode_stage (
    .rst      (rst),
    .inst     (inst),
    .redirect (redirect),
    .wf_rd    (wf_rd),
    .wf_we    (wf_we),
    .d_inst   (d_inst),
    .pc_sel   (pc_sel),
    .nop_sel  (nop_sel),
    .d_fwd_a  (d_fwd_a),
    .d_fwd_b  (d_fwd_b)
  );

  exec_stage u_exec_stage (
    .clk      (clk),
    .rst      (rst),
    .d_inst   (d_inst),
    .br_eq    (br_eq),
    .br_lt    (br_lt),
    .wf_rd    (wf_rd),
    .wf_we    (wf_we),
    .wf_load  (wf_load),
    .x_inst   (x_inst),
    .redirect (redirect),
    .br_taken (br_taken),
    .alu_sel  (alu_sel),
    .a_sel    (a_sel),
    .b_sel    (b_sel),
    .br_un    (br_un),
    .x_fwd_a  (x_fwd_a),
    .x_fwd_b  (x_fwd_b),
    .rs2_sel  (rs2_sel)
  );

  wb_stage u_wb_stage (
    .clk      (clk),
    .rst      (rst),
    .x_inst   (x_inst),
    .rf_we    (rf_we),
    .wb_sel   (wb_sel),
    .ldx_sel  (ldx_sel),
    .wf_rd    (wf_rd),
    .wf_we    (wf_we),
    .wf_load  (wf_load)
  );

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl_pkg.sv
/* Shared constants for the RV32I pipeline control path.
   Field positions, opcode and funct3 codes, and the datapath select encodings */
`default_nettype none

package pipe_ctrl_pkg;

  localparam int INST_W = 32;
  localparam int REG_W  = 5;

  // Instruction field positions
  localparam int OPC_LSB = 2;  // Low two bits are always 2'b11
  localparam int OPC_W   = 5;
  localparam int RD_LSB  = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F3_LSB  = 12;
  localparam int F7_BIT  = 30; // Picks sub and sra

  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  localparam logic [OPC_W-1:0] OPC_RTYPE  = 5'b01100;
  localparam logic [OPC_W-1:0] OPC_ITYPE  = 5'b00100;
  localparam logic [OPC_W-1:0] OPC_LOAD   = 5'b00000;
  localparam logic [OPC_W-1:0] OPC_STORE  = 5'b01000;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 5'b11000;
  localparam logic [OPC_W-1:0] OPC_JAL    = 5'b11011;
  localparam logic [OPC_W-1:0] OPC_JALR   = 5'b11001;
  localparam logic [OPC_W-1:0] OPC_AUIPC  = 5'b00101;
  localparam logic [OPC_W-1:0] OPC_LUI    = 5'b01101;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load funct3
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // ALU funct3, shared by R and I types
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl or sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;
  localparam logic [3:0] ALU_LUI  = 4'd10; // Pass immediate through

  localparam logic [1:0] FWD_REG = 2'd0;
  localparam logic [1:0] FWD_ALU = 2'd1;
  localparam logic [1:0] FWD_MEM = 2'd2;

  localparam logic A_RS1 = 1'b0;
  localparam logic A_PC  = 1'b1;

  localparam logic [1:0] WB_MEM = 2'd0;
  localparam logic [1:0] WB_ALU = 2'd1;
  localparam logic [1:0] WB_PC4 = 2'd2;

  localparam logic [1:0] PC_RESET    = 2'd0;
  localparam logic [1:0] PC_JAL      = 2'd1;
  localparam logic [1:0] PC_NEXT     = 2'd2;
  localparam logic [1:0] PC_REDIRECT = 2'd3; // Branch or jalr target from X

  localparam logic [2:0] LDX_W  = 3'd0;
  localparam logic [2:0] LDX_HU = 3'd1;
  localparam logic [2:0] LDX_H  = 3'd2;
  localparam logic [2:0] LDX_BU = 3'd3;
  localparam logic [2:0] LDX_B  = 3'd4;

endpackage

`default_nettype wire

// File: rtl/wb_stage.sv
/* Write-back stage control. Holds the WF instruction and decodes register
   write, write-back source, load extension and the writer info for forwarding */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [pipe_ctrl_pkg::INST_W-1:0] x_inst,
  output logic                                 rf_we,
  output logic      [1:0]                      wb_sel,
  output logic      [2:0]                      ldx_sel,
  output logic      [pipe_ctrl_pkg::REG_W-1:0]  wf_rd,
  output logic                                 wf_we,
  output logic                                 wf_load
);

  logic [pipe_ctrl_pkg::INST_W-1:0] wf_inst;
  logic [pipe_ctrl_pkg::OPC_W-1:0]  opc;
  logic [2:0]                       f3;
  logic                             writes_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      wf_inst <= pipe_ctrl_pkg::NOP_INST;
    end else begin
      wf_inst <= x_inst;
    end
  end

  assign opc   = wf_inst[pipe_ctrl_pkg::OPC_LSB +: pipe_ctrl_pkg::OPC_W];
  assign f3    = wf_inst[pipe_ctrl_pkg::F3_LSB +: 3];
  assign wf_rd = wf_inst[pipe_ctrl_pkg::RD_LSB +: pipe_ctrl_pkg::REG_W];

  always_comb begin
    writes_rd = 1'b1;
    wb_sel    = pipe_ctrl_pkg::WB_ALU;
    case (opc)
      pipe_ctrl_pkg::OPC_LOAD:  wb_sel = pipe_ctrl_pkg::WB_MEM;
      pipe_ctrl_pkg::OPC_JAL,
      pipe_ctrl_pkg::OPC_JALR:  wb_sel = pipe_ctrl_pkg::WB_PC4; // Link address
      pipe_ctrl_pkg::OPC_RTYPE,
      pipe_ctrl_pkg::OPC_ITYPE,
      pipe_ctrl_pkg::OPC_AUIPC,
      pipe_ctrl_pkg::OPC_LUI:   wb_sel = pipe_ctrl_pkg::WB_ALU;
      default: begin // Stores and branches
        writes_rd = 1'b0;
        wb_sel    = pipe_ctrl_pkg::WB_MEM;
      end
    endcase
  end

  assign rf_we   = writes_rd && (wf_rd != '0);
  assign wf_we   = rf_we;
  assign wf_load = (opc == pipe_ctrl_pkg::OPC_LOAD);

  always_comb begin
    ldx_sel = pipe_ctrl_pkg::LDX_W;
    if (wf_load) begin
      case (f3)
        pipe_ctrl_pkg::F3_LB:  ldx_sel = pipe_ctrl_pkg::LDX_B;
        pipe_ctrl_pkg::F3_LH:  ldx_sel = pipe_ctrl_pkg::LDX_H;
        pipe_ctrl_pkg::F3_LW:  ldx_sel = pipe_ctrl_pkg::LDX_W;
        pipe_ctrl_pkg::F3_LBU: ldx_sel = pipe_ctrl_pkg::LDX_BU;
        pipe_ctrl_pkg::F3_LHU: ldx_sel = pipe_ctrl_pkg::LDX_HU;
        default:               ldx_sel = pipe_ctrl_pkg::LDX_W;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verif/pipe_ctrl_chk.sv
/* Assertions on redirect and reset behavior of the control path.
   Bound into the top level by the testbench */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_chk (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic [1:0] pc_sel,
  input wire logic       nop_sel,
  input wire logic       br_taken,
  input wire logic       rf_we
);

  // A kill always comes with the redirect target
  a_kill_redirect: assert property (
    @(posedge clk) disable iff (rst) nop_sel |-> (pc_sel == pipe_ctrl_pkg::PC_REDIRECT)
  ) else $error("nop_sel without a redirect pc_sel");

  // Killed instruction reaches X as a NOP
  a_killed_not_taken: assert property (
    @(posedge clk) disable iff (rst) nop_sel |=> !br_taken
  ) else $error("br_taken in the cycle after a kill");

  // WF holds a NOP once reset has been seen
  a_reset_no_write: assert property (
    @(posedge clk) rst |=> !rf_we
  ) else $error("rf_we high after reset");

endmodule

`default_nettype wire

// File: verif/pipe_ctrl_tb.sv
/* Table-driven testbench for the pipeline control path. Each row is presented in D
   and its D, X and WF outputs are checked in three consecutive cycles */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic        br_eq;
  logic        br_lt;
  logic [1:0]  pc_sel;
  logic        nop_sel;
  logic        d_fwd_a;
  logic        d_fwd_b;
  logic        a_sel;
  logic        b_sel;
  logic [3:0]  alu_sel;
  logic        br_un;
  logic        br_taken;
  logic [1:0]  x_fwd_a;
  logic [1:0]  x_fwd_b;
  logic [1:0]  rs2_sel;
  logic        rf_we;
  logic [1:0]  wb_sel;
  logic [2:0]  ldx_sel;

  logic [31:0] inst_q[$];
  logic [1:0]  cmp_q[$];  // {br_eq, br_lt} for the row while it is in X
  logic [4:0]  d_q[$];
  logic [13:0] x_q[$];
  logic [5:0]  w_q[$];
  int          cycles;

  pipe_ctrl UUT (.*);

  bind pipe_ctrl pipe_ctrl_chk u_chk (
    .clk(clk), .rst(rst), .pc_sel(pc_sel), .nop_sel(nop_sel), .br_taken(br_taken),
    .rf_we(rf_we)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit from reset length plus table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 10 + inst_q.size() + 10) begin
      $display("Timeout: the run went past its cycle limit");
      $display("Checks failed");
      $fatal(1);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Instruction encoders in the RV32I field layout
  function automatic logic [31:0] enc(input logic [4:0] opc, input int rd, input int f3,
                                      input int rs1, input int rs2, input int b30);
    enc = {1'b0, b30[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc, 2'b11};
  endfunction

  function automatic logic [31:0] r_op(input int rd, input int rs1, input int rs2,
                                       input int f3, input int b30);
    r_op = enc(pipe_ctrl_pkg::OPC_RTYPE, rd, f3, rs1, rs2, b30);
  endfunction

  function automatic logic [31:0] i_op(input int rd, input int f3, input int b30);
    i_op = enc(pipe_ctrl_pkg::OPC_ITYPE, rd, f3, 0, 0, b30);
  endfunction

  function automatic logic [31:0] ld_op(input int rd, input int f3);
    ld_op = enc(pipe_ctrl_pkg::OPC_LOAD, rd, f3, 0, 0, 0);
  endfunction

  function automatic logic [31:0] st_op(input int rs2);
    st_op = enc(pipe_ctrl_pkg::OPC_STORE, 0, 2, 0, rs2, 0);
  endfunction

  function automatic logic [31:0] br_op(input int f3);
    br_op = enc(pipe_ctrl_pkg::OPC_BRANCH, 0, f3, 0, 0, 0);
  endfunction

  function automatic logic [4:0] d_exp(input int pc, input int nop, input int fa, input int fb);
    d_exp = {pc[1:0], nop[0], fa[0], fb[0]};
  endfunction

  function automatic logic [13:0] x_exp(input int alu, input int a, input int b, input int un,
                                        input int tk, input int fa, input int fb, input int rs);
    x_exp = {alu[3:0], a[0], b[0], un[0], tk[0], fa[1:0], fb[1:0], rs[1:0]};
  endfunction

  function automatic logic [5:0] w_exp(input int we, input int wb, input int ldx);
    w_exp = {we[0], wb[1:0], ldx[2:0]};
  endfunction

  task automatic add_row(input logic [31:0] i, input int cmp, input logic [4:0] d,
                         input logic [13:0] x, input logic [5:0] w);
    inst_q.push_back(i);
    cmp_q.push_back(cmp[1:0]);
    d_q.push_back(d);
    x_q.push_back(x);
    w_q.push_back(w);
  endtask

  // Killed instruction in D shows up as a NOP in X and WF
  task automatic add_victim(input logic [31:0] i);
    add_row(i, 0, d_exp(3, 1, 0, 0), x_exp(0, 0, 1, 0, 0, 0, 0, 0), w_exp(0, 1, 0));
  endtask

  task automatic build_table();
    // ALU decode of R and I types
    add_row(r_op(1, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(2, 0, 0, 0, 1), 0, d_exp(2,0,0,0), x_exp(1,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(3, 0, 0, 1, 0), 0, d_exp(2,0,0,0), x_exp(5,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(4, 0, 0, 2, 0), 0, d_exp(2,0,0,0), x_exp(8,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(5, 0, 0, 3, 0), 0, d_exp(2,0,0,0), x_exp(9,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(6, 0, 0, 4, 0), 0, d_exp(2,0,0,0), x_exp(4,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(7, 0, 0, 5, 0), 0, d_exp(2,0,0,0), x_exp(6,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(8, 0, 0, 5, 1), 0, d_exp(2,0,0,0), x_exp(7,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(9, 0, 0, 6, 0), 0, d_exp(2,0,0,0), x_exp(3,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(10, 0, 0, 7, 0), 0, d_exp(2,0,0,0), x_exp(2,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(11, 0, 1), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(12, 1, 0), 0, d_exp(2,0,0,0), x_exp(5,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(13, 2, 0), 0, d_exp(2,0,0,0), x_exp(8,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(14, 3, 0), 0, d_exp(2,0,0,0), x_exp(9,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(15, 4, 0), 0, d_exp(2,0,0,0), x_exp(4,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(16, 5, 0), 0, d_exp(2,0,0,0), x_exp(6,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(17, 5, 1), 0, d_exp(2,0,0,0), x_exp(7,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(18, 6, 0), 0, d_exp(2,0,0,0), x_exp(3,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(i_op(19, 7, 0), 0, d_exp(2,0,0,0), x_exp(2,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(enc(pipe_ctrl_pkg::OPC_LUI, 20, 0, 0, 0, 0), 0, d_exp(2,0,0,0),
            x_exp(10,0,1,0,0,0,0,0), w_exp(1,1,0));
    add_row(enc(pipe_ctrl_pkg::OPC_AUIPC, 21, 0, 0, 0, 0), 0, d_exp(2,0,0,0),
            x_exp(0,1,1,0,0,0,0,0), w_exp(1,1,0));
    // Loads lb lh lw lbu lhu and a store
    add_row(ld_op(22, 0), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,4));
    add_row(ld_op(23, 1), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,2));
    add_row(ld_op(24, 2), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,0));
    add_row(ld_op(25, 4), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,3));
    add_row(ld_op(26, 5), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,1));
    add_row(st_op(0), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(0,0,0));
    // X forwarding from ALU and load writers
    add_row(r_op(5, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(6, 5, 5, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,1,1,0), w_exp(1,1,0));
    add_row(ld_op(7, 2), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,0));
    add_row(r_op(8, 7, 7, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,2,2,0), w_exp(1,1,0));
    add_row(st_op(8), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,1), w_exp(0,0,0));
    add_row(ld_op(9, 2), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,0), w_exp(1,0,0));
    add_row(st_op(9), 0, d_exp(2,0,0,0), x_exp(0,0,1,0,0,0,0,2), w_exp(0,0,0));
    add_row(r_op(0, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(0,1,0));
    add_row(r_op(11, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    // Decode bypass with the writer two rows ahead
    add_row(r_op(12, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(13, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    add_row(r_op(14, 12, 12, 0, 0), 0, d_exp(2,0,1,1), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
    // Branches with cmp as {eq, lt}
    add_row(br_op(0), 2, d_exp(2,0,0,0), x_exp(0,1,1,0,1,0,0,0), w_exp(0,0,0));
    add_victim(r_op(15, 0, 0, 0, 0));
    add_row(br_op(0), 0, d_exp(2,0,0,0), x_exp(0,1,1,0,0,0,0,0), w_exp(0,0,0));
    add_row(br_op(1), 0, d_exp(2,0,0,0), x_exp(0,1,1,0,1,0,0,0), w_exp(0,0,0));
    add_victim(enc(pipe_ctrl_pkg::OPC_JAL, 1, 0, 0, 0, 0)); // Redirect beats jal
    add_row(br_op(1), 2, d_exp(2,0,0,0), x_exp(0,1,1,0,0,0,0,0), w_exp(0,0,0));
    add_row(br_op(4), 1, d_exp(2,0,0,0), x_exp(0,1,1,0,1,0,0,0), w_exp(0,0,0));
    add_victim(br_op(1)); // Would be taken in X if it escaped the kill
    add_row(br_op(4), 0, d_exp(2,0,0,0), x_exp(0,1,1,0,0,0,0,0), w_exp(0,0,0));
    add_row(br_op(5), 0, d_exp(2,0,0,0), x_exp(0,1,1,0,1,0,0,0), w_exp(0,0,0));
    add_victim(r_op(16, 0, 0, 0, 0));
    add_row(br_op(5), 1, d_exp(2,0,0,0), x_exp(0,1,1,0,0,0,0,0), w_exp(0,0,0));
    add_row(br_op(6), 1, d_exp(2,0,0,0), x_exp(0,1,1,1,1,0,0,0), w_exp(0,0,0));
    add_victim(r_op(16, 0, 0, 0, 0));
    add_row(br_op(6), 0, d_exp(2,0,0,0), x_exp(0,1,1,1,0,0,0,0), w_exp(0,0,0));
    add_row(br_op(7), 0, d_exp(2,0,0,0), x_exp(0,1,1,1,1,0,0,0), w_exp(0,0,0));
    add_victim(r_op(16, 0, 0, 0, 0));
    add_row(br_op(7), 1, d_exp(2,0,0,0), x_exp(0,1,1,1,0,0,0,0), w_exp(0,0,0));
    // Jumps
    add_row(enc(pipe_ctrl_pkg::OPC_JAL, 1, 0, 0, 0, 0), 0, d_exp(1,0,0,0),
            x_exp(0,1,1,0,0,0,0,0), w_exp(1,2,0));
    add_row(enc(pipe_ctrl_pkg::OPC_JALR, 2, 0, 0, 0, 0), 0, d_exp(2,0,0,0),
            x_exp(0,0,1,0,0,0,0,0), w_exp(1,2,0));
    add_victim(r_op(17, 0, 0, 0, 0));
    add_row(r_op(18, 0, 0, 0, 0), 0, d_exp(2,0,0,0), x_exp(0,0,0,0,0,0,0,0), w_exp(1,1,0));
  endtask

  initial begin
    int n;
    int k;
    logic [4:0]  d;
    logic [13:0] x;
    logic [5:0]  w;
    cycles = 0;
    rst    = 1'b1;
    inst   = pipe_ctrl_pkg::NOP_INST;
    br_eq  = 1'b0;
    br_lt  = 1'b0;
    build_table();
    n = inst_q.size();
    repeat (10) @(negedge clk);
    check("pc_sel", 32'(pc_sel), 32'(pipe_ctrl_pkg::PC_RESET));
    rst = 1'b0;
    #1;
    // Pipeline holds NOPs straight after reset
    check("rf_we", 32'(rf_we), 0);
    check("br_taken", 32'(br_taken), 0);
    check("nop_sel", 32'(nop_sel), 0);
    check("d_fwd_a", 32'(d_fwd_a), 0);
    check("d_fwd_b", 32'(d_fwd_b), 0);
    check("x_fwd_a", 32'(x_fwd_a), 0);
    check("x_fwd_b", 32'(x_fwd_b), 0);
    check("rs2_sel", 32'(rs2_sel), 0);
    check("alu_sel", 32'(alu_sel), 32'(pipe_ctrl_pkg::ALU_ADD));
    for (k = 0; k < n + 2; k++) begin
      @(negedge clk);
      inst  = (k < n) ? inst_q[k] : pipe_ctrl_pkg::NOP_INST;
      br_eq = (k >= 1 && k <= n) ? cmp_q[k-1][1] : 1'b0; // Compare of the row now in X
      br_lt = (k >= 1 && k <= n) ? cmp_q[k-1][0] : 1'b0;
      #1;
      if (k < n) begin
        d = d_q[k];
        check("pc_sel", 32'(pc_sel), 32'(d[4:3]));
        check("nop_sel", 32'(nop_sel), 32'(d[2]));
        check("d_fwd_a", 32'(d_fwd_a), 32'(d[1]));
        check("d_fwd_b", 32'(d_fwd_b), 32'(d[0]));
      end
      if (k >= 1 && k <= n) begin
        x = x_q[k-1];
        check("alu_sel", 32'(alu_sel), 32'(x[13:10]));
        check("a_sel", 32'(a_sel), 32'(x[9]));
        check("b_sel", 32'(b_sel), 32'(x[8]));
        check("br_un", 32'(br_un), 32'(x[7]));
        check("br_taken", 32'(br_taken), 32'(x[6]));
        check("x_fwd_a", 32'(x_fwd_a), 32'(x[5:4]));
        check("x_fwd_b", 32'(x_fwd_b), 32'(x[3:2]));
        check("rs2_sel", 32'(rs2_sel), 32'(x[1:0]));
      end
      if (k >= 2) begin
        w = w_q[k-2];
        check("rf_we", 32'(rf_we), 32'(w[5]));
        check("wb_sel", 32'(wb_sel), 32'(w[4:3]));
        check("ldx_sel", 32'(ldx_sel), 32'(w[2:0]));
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
